/* include/panel_defines.svh */
//////////////////////////////
// panel geometry and brightness depth
// include wherever widths are needed
//////////////////////////////
`ifndef PANEL_DEFINES_SVH
`define PANEL_DEFINES_SVH

// 32 rows
`define PANEL_ROW_BITS 5

// 64 columns
`define PANEL_COL_BITS 6

// two bytes per pixel
`define PANEL_BYTE_SEL_BITS 1

// one frame-memory byte address
`define PANEL_MEM_ADDR_BITS (`PANEL_ROW_BITS + `PANEL_COL_BITS + `PANEL_BYTE_SEL_BITS)

// bits in the brightness mask
`define BRIGHTNESS_LEVELS 6

`endif

/* hdl/panel_pkg.sv */
//////////////////////////////
// shared types for the panel command controller
// import into any block that uses them
//////////////////////////////
`default_nettype none

package panel_pkg;

    `include "panel_defines.svh"

    typedef logic [`PANEL_ROW_BITS-1:0] row_addr_t;
    typedef logic [`PANEL_COL_BITS-1:0] col_addr_t;
    typedef logic [`PANEL_BYTE_SEL_BITS-1:0] byte_sel_t;

    // row, column, inverted byte select
    typedef logic [`PANEL_MEM_ADDR_BITS-1:0] mem_addr_t;

    typedef logic [7:0] mem_data_t;
    typedef logic [7:0] rx_byte_t;
    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_t;

    // red bit 0, green bit 1, blue bit 2
    typedef logic [2:0] rgb_enable_t;

    typedef enum logic [7:0] {
        CMD_RED_ENABLE         = 8'h01,
        CMD_RED_DISABLE        = 8'h02,
        CMD_GREEN_ENABLE       = 8'h03,
        CMD_GREEN_DISABLE      = 8'h04,
        CMD_BLUE_ENABLE        = 8'h05,
        CMD_BLUE_DISABLE       = 8'h06,
        CMD_BRIGHTNESS_ZERO    = 8'h10,
        CMD_BRIGHTNESS_ONE     = 8'h11,
        CMD_BRIGHTNESS_TWO     = 8'h12,
        CMD_BRIGHTNESS_THREE   = 8'h13,
        CMD_BRIGHTNESS_FOUR    = 8'h14,
        CMD_BRIGHTNESS_FIVE    = 8'h15,
        CMD_BRIGHTNESS_SIX     = 8'h16,
        CMD_BRIGHTNESS_NINE    = 8'h19,
        CMD_READ_BRIGHTNESS    = 8'h20,
        CMD_BLANK_PANEL        = 8'h21,
        CMD_READ_PIXEL         = 8'h22
    } cmd_opcode_t;

    typedef enum logic [1:0] {
        ST_IDLE            = 2'd0,
        ST_READ_BRIGHTNESS = 2'd1,
        ST_BLANK_PANEL     = 2'd2,
        ST_READ_PIXEL      = 2'd3
    } cmd_state_t;

endpackage

`default_nettype wire

/* hdl/cmd_dispatch.sv */
//////////////////////////////
// opcode decoder and command FSM
// also owns channel enables and brightness mask
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cmd_dispatch
    import panel_pkg::*;
(
    input  wire logic        clk_in,
    input  wire logic        reset,
    input  wire rx_byte_t    rx_byte,
    input  wire logic        byte_valid,
    input  wire logic        cmd_done,
    input  wire logic        brightness_load,
    input  wire brightness_t brightness_value,
    output cmd_state_t       cmd_state,
    output rgb_enable_t      rgb_enable,
    output brightness_t      brightness_enable
);

    localparam int LEVELS = $bits(brightness_t);

    // mask as last written, output copies it a cycle later
    brightness_t brightness_pending;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            cmd_state          <= ST_IDLE;
            rgb_enable         <= '1;
            brightness_pending <= '1;
            brightness_enable  <= '1;
        end else begin
            brightness_enable <= brightness_pending;

            if (brightness_load) begin
                brightness_pending <= brightness_value;
            end

            if (cmd_state != ST_IDLE) begin
                if (cmd_done) begin
                    cmd_state <= ST_IDLE;
                end
            end else if (byte_valid) begin
                case (cmd_opcode_t'(rx_byte))
                    CMD_RED_ENABLE:    rgb_enable[0] <= 1'b1;
                    CMD_RED_DISABLE:   rgb_enable[0] <= 1'b0;
                    CMD_GREEN_ENABLE:  rgb_enable[1] <= 1'b1;
                    CMD_GREEN_DISABLE: rgb_enable[1] <= 1'b0;
                    CMD_BLUE_ENABLE:   rgb_enable[2] <= 1'b1;
                    CMD_BLUE_DISABLE:  rgb_enable[2] <= 1'b0;

                    // level k flips mask bit LEVELS-k, so level one is the msb
                    CMD_BRIGHTNESS_ONE: begin
                        brightness_pending[LEVELS-1] <= ~brightness_pending[LEVELS-1];
                    end
                    CMD_BRIGHTNESS_TWO: begin
                        brightness_pending[LEVELS-2] <= ~brightness_pending[LEVELS-2];
                    end
                    CMD_BRIGHTNESS_THREE: begin
                        brightness_pending[LEVELS-3] <= ~brightness_pending[LEVELS-3];
                    end
                    CMD_BRIGHTNESS_FOUR: begin
                        brightness_pending[LEVELS-4] <= ~brightness_pending[LEVELS-4];
                    end
                    CMD_BRIGHTNESS_FIVE: begin
                        brightness_pending[LEVELS-5] <= ~brightness_pending[LEVELS-5];
                    end
                    CMD_BRIGHTNESS_SIX: begin
                        brightness_pending[LEVELS-6] <= ~brightness_pending[LEVELS-6];
                    end
                    CMD_BRIGHTNESS_ZERO: brightness_pending <= '0;
                    CMD_BRIGHTNESS_NINE: brightness_pending <= '1;

                    // multi-byte commands
                    CMD_READ_BRIGHTNESS: cmd_state <= ST_READ_BRIGHTNESS;
                    CMD_BLANK_PANEL:     cmd_state <= ST_BLANK_PANEL;
                    CMD_READ_PIXEL:      cmd_state <= ST_READ_PIXEL;

                    // unknown opcodes are dropped
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cmd_read_brightness.sv */
//////////////////////////////
// read brightness command
// one argument byte becomes the new mask
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cmd_read_brightness
    import panel_pkg::*;
(
    input  wire logic     clk_in,
    input  wire logic     reset,
    input  wire logic     arg_valid,
    input  wire rx_byte_t arg_byte,
    output logic          brightness_load,
    output brightness_t   brightness_value,
    output logic          done
);

    logic taken;

    // only the first argument counts
    assign brightness_load  = arg_valid && !taken;
    assign brightness_value = arg_byte[$bits(brightness_t)-1:0];
    assign done             = brightness_load;

    // blocks a second byte while the FSM drops back to idle
    always_ff @(posedge clk_in) begin
        if (reset) begin
            taken <= 1'b0;
        end else begin
            taken <= done;
        end
    end

endmodule

`default_nettype wire

/* hdl/cmd_read_pixel.sv */
//////////////////////////////
// read pixel command
// row, column, then two data bytes written out
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cmd_read_pixel
    import panel_pkg::*;
(
    input  wire logic     clk_in,
    input  wire logic     reset,
    input  wire logic     arg_valid,
    input  wire rx_byte_t arg_byte,
    output row_addr_t     row,
    output col_addr_t     column,
    output byte_sel_t     byte_sel,
    output mem_data_t     write_data,
    output logic          write_enable,
    output logic          done
);

    typedef enum logic [1:0] {
        ARG_ROW    = 2'd0,
        ARG_COLUMN = 2'd1,
        ARG_DATA0  = 2'd2,
        ARG_DATA1  = 2'd3
    } arg_step_t;

    arg_step_t step;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            step <= ARG_ROW;
        end else if (arg_valid) begin
            // wraps back to ARG_ROW after the second data byte
            step <= arg_step_t'(step + 2'd1);
        end
    end

    // captured coordinates
    always_ff @(posedge clk_in) begin
        if (arg_valid && step == ARG_ROW) begin
            row <= arg_byte[$bits(row_addr_t)-1:0];
        end
        if (arg_valid && step == ARG_COLUMN) begin
            column <= arg_byte[$bits(col_addr_t)-1:0];
        end
    end

    // data bytes go straight through in their own cycle
    assign write_data   = arg_byte;
    assign byte_sel     = byte_sel_t'(step == ARG_DATA1);
    assign write_enable = arg_valid && (step == ARG_DATA0 || step == ARG_DATA1);
    assign done         = arg_valid && step == ARG_DATA1;

endmodule

`default_nettype wire

/* hdl/cmd_blank_panel.sv */
//////////////////////////////
// blank panel command
// clears every frame byte, one per clock
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cmd_blank_panel
    import panel_pkg::*;
(
    input  wire logic clk_in,
    input  wire logic reset,
    input  wire logic start,
    output row_addr_t row,
    output col_addr_t column,
    output byte_sel_t byte_sel,
    output logic      write_enable,
    output logic      done
);

    mem_addr_t count;
    byte_sel_t sel_low;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            count <= '0;
        end else if (start && !done) begin
            count <= count + 1'b1;
        end else begin
            count <= '0;
        end
    end

    // the top inverts byte select, undo it so ram_address tracks count
    assign {row, column, sel_low} = count;
    assign byte_sel = ~sel_low;

    assign write_enable = start;
    assign done         = start && (count == '1);

endmodule

`default_nettype wire

/* hdl/panel_control.sv */
//////////////////////////////
// top of the panel command controller
// byte input, command blocks and the write port
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module panel_control
    import panel_pkg::*;
(
    input  wire logic     clk_in,
    input  wire logic     reset,
    input  wire rx_byte_t data_rx,
    input  wire logic     data_ready_n,
    output rgb_enable_t   rgb_enable,
    output brightness_t   brightness_enable,
    output mem_addr_t     ram_address,
    output mem_data_t     ram_data_out,
    output logic          ram_write_enable,
    output logic          busy,
    output logic          ready_for_data
);

    rx_byte_t   rx_byte;
    logic       byte_valid;
    cmd_state_t cmd_state;
    logic       cmd_done;

    logic        rb_load;
    brightness_t rb_value;
    logic        rb_done;

    row_addr_t rp_row;
    col_addr_t rp_column;
    byte_sel_t rp_byte_sel;
    mem_data_t rp_data;
    logic      rp_we;
    logic      rp_done;

    row_addr_t bp_row;
    col_addr_t bp_column;
    byte_sel_t bp_byte_sel;
    logic      bp_we;
    logic      bp_done;

    row_addr_t sel_row;
    col_addr_t sel_column;
    byte_sel_t sel_byte;

    // input byte register, byte_valid follows the accepting edge
    always_ff @(posedge clk_in) begin
        if (!data_ready_n && ready_for_data) begin
            rx_byte <= data_rx;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= !data_ready_n && ready_for_data;
        end
    end

    cmd_dispatch u_dispatch (
        .clk_in           (clk_in),
        .reset            (reset),
        .rx_byte          (rx_byte),
        .byte_valid       (byte_valid),
        .cmd_done         (cmd_done),
        .brightness_load  (rb_load),
        .brightness_value (rb_value),
        .cmd_state        (cmd_state),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable)
    );

    cmd_read_brightness u_read_brightness (
        .clk_in          (clk_in),
        .reset           (reset),
        .arg_valid       (byte_valid && cmd_state == ST_READ_BRIGHTNESS),
        .arg_byte        (rx_byte),
        .brightness_load (rb_load),
        .brightness_value(rb_value),
        .done            (rb_done)
    );

    cmd_read_pixel u_read_pixel (
        .clk_in      (clk_in),
        .reset       (reset),
        .arg_valid   (byte_valid && cmd_state == ST_READ_PIXEL),
        .arg_byte    (rx_byte),
        .row         (rp_row),
        .column      (rp_column),
        .byte_sel    (rp_byte_sel),
        .write_data  (rp_data),
        .write_enable(rp_we),
        .done        (rp_done)
    );

    cmd_blank_panel u_blank_panel (
        .clk_in      (clk_in),
        .reset       (reset),
        .start       (cmd_state == ST_BLANK_PANEL),
        .row         (bp_row),
        .column      (bp_column),
        .byte_sel    (bp_byte_sel),
        .write_enable(bp_we),
        .done        (bp_done)
    );

    // write port and done follow the active command
    always_comb begin
        sel_row          = '0;
        sel_column       = '0;
        sel_byte         = '0;
        ram_data_out     = '0;
        ram_write_enable = 1'b0;
        cmd_done         = 1'b0;
        case (cmd_state)
            ST_READ_BRIGHTNESS: begin
                cmd_done = rb_done;
            end
            ST_READ_PIXEL: begin
                sel_row          = rp_row;
                sel_column       = rp_column;
                sel_byte         = rp_byte_sel;
                ram_data_out     = rp_data;
                ram_write_enable = rp_we;
                cmd_done         = rp_done;
            end
            ST_BLANK_PANEL: begin
                sel_row          = bp_row;
                sel_column       = bp_column;
                sel_byte         = bp_byte_sel;
                ram_write_enable = bp_we;
                cmd_done         = bp_done;
            end
            default: begin
            end
        endcase
    end

    // inverted select keeps pixels little-endian in memory
    assign ram_address = {sel_row, sel_column, ~sel_byte};

    assign busy           = cmd_state != ST_IDLE;
    assign ready_for_data = cmd_state != ST_BLANK_PANEL;

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
//////////////////////////////
// testbench clock and reset
// 4 ns clk_in, reset high for 10 cycles
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_in,
    output logic reset
);

    initial begin
        clk_in = 1'b0;
    end

    always #2 clk_in = ~clk_in;

    // released on a falling edge like every other input
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tb/panel_control_tb.sv */
//////////////////////////////
// directed testbench for panel_control
// run from sim.f, top is panel_control_tb
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "panel_defines.svh"

module panel_control_tb
    import panel_pkg::*;
;

    localparam int MEM_BYTES = 1 << `PANEL_MEM_ADDR_BITS;
    // three blank-panel lengths plus slack for the short tests
    localparam int WATCHDOG_CYCLES = MEM_BYTES * 3 + 2000;

    logic        clk_in;
    logic        reset;
    rx_byte_t    data_rx;
    logic        data_ready_n;
    rgb_enable_t rgb_enable;
    brightness_t brightness_enable;
    mem_addr_t   ram_address;
    mem_data_t   ram_data_out;
    logic        ram_write_enable;
    logic        busy;
    logic        ready_for_data;

    mem_data_t   shadow [0:MEM_BYTES-1];
    int          write_count;
    logic [15:0] lfsr_state;
    rgb_enable_t rgb_model;

    tb_clock_gen u_clock_gen (
        .clk_in(clk_in),
        .reset (reset)
    );

    panel_control DUT (
        .clk_in           (clk_in),
        .reset            (reset),
        .data_rx          (data_rx),
        .data_ready_n     (data_ready_n),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable),
        .busy             (busy),
        .ready_for_data   (ready_for_data)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rgb(input string test, input rgb_enable_t expected,
                             input rgb_enable_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s: rgb_enable expected %b actual %b",
                                        test, expected, actual));
        end
    endtask

    task automatic check_brightness(input string test, input brightness_t expected,
                                    input brightness_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s: brightness expected %h actual %h",
                                        test, expected, actual));
        end
    endtask

    task automatic check_mem(input string test, input mem_addr_t addr,
                             input mem_data_t expected);
        if (shadow[addr] !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s: mem[%h] expected %h actual %h",
                                        test, addr, expected, shadow[addr]));
        end
    endtask

    task automatic check_count(input string test, input int expected, input int actual);
        if (actual != expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s: write count expected %0d actual %0d",
                                        test, expected, actual));
        end
    endtask

    task automatic check_flag(input string test, input string flag, input logic expected,
                              input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s: %s expected %b actual %b",
                                        test, flag, expected, actual));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_byte(output logic [7:0] value);
        value = '0;
        repeat (8) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_in);
    endtask

    // one-cycle strobe once the receiver side is open
    task automatic send_byte(input rx_byte_t value);
        @(negedge clk_in);
        while (!ready_for_data) @(negedge clk_in);
        data_rx      = value;
        data_ready_n = 1'b0;
        @(negedge clk_in);
        data_ready_n = 1'b1;
    endtask

    // busy has to fall within max_cycles edges
    task automatic wait_until_idle(input string test, input int max_cycles);
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles == max_cycles) begin
                stop_with_failure($sformatf("%s: busy still high after %0d cycles",
                                            test, max_cycles));
            end
            @(negedge clk_in);
            cycles++;
        end
    endtask

    // records every write on the frame-memory port
    always @(negedge clk_in) begin
        if (ram_write_enable === 1'b1) begin
            shadow[ram_address] = ram_data_out;
            write_count = write_count + 1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic test_reset_state();
        check_rgb("reset", '1, rgb_enable);
        check_brightness("reset", '1, brightness_enable);
        check_flag("reset", "busy", 1'b0, busy);
        check_flag("reset", "ready_for_data", 1'b1, ready_for_data);
        check_flag("reset", "ram_write_enable", 1'b0, ram_write_enable);
    endtask

    task automatic test_channel_opcodes();
        send_byte(CMD_RED_DISABLE);
        send_byte(CMD_BLUE_DISABLE);
        send_byte(CMD_RED_ENABLE);
        rgb_model[0] = 1'b0;
        rgb_model[2] = 1'b0;
        rgb_model[0] = 1'b1;
        idle_cycles(4);
        check_rgb("channel opcodes", rgb_model, rgb_enable);
    endtask

    task automatic test_brightness_opcodes();
        brightness_t expected;
        send_byte(CMD_BRIGHTNESS_ZERO);
        idle_cycles(4);
        check_brightness("brightness zero", '0, brightness_enable);

        // level k toggles bit LEVELS-k
        send_byte(CMD_BRIGHTNESS_ONE);
        send_byte(CMD_BRIGHTNESS_THREE);
        expected = '0;
        expected[`BRIGHTNESS_LEVELS-1] = 1'b1;
        expected[`BRIGHTNESS_LEVELS-3] = 1'b1;
        idle_cycles(4);
        check_brightness("brightness one and three", expected, brightness_enable);

        send_byte(8'h7e);
        idle_cycles(4);
        check_brightness("unknown opcode", expected, brightness_enable);

        send_byte(CMD_BRIGHTNESS_NINE);
        idle_cycles(4);
        check_brightness("brightness nine", '1, brightness_enable);
    endtask

    task automatic test_read_brightness();
        send_byte(CMD_READ_BRIGHTNESS);
        send_byte(8'h2a);
        // done drops back to idle on the next edge
        wait_until_idle("read brightness", 1);
        idle_cycles(3);
        check_brightness("read brightness", 6'h2a, brightness_enable);
    endtask

    task automatic write_random_pixel(input string test);
        logic [7:0] row_byte;
        logic [7:0] col_byte;
        logic [7:0] data0;
        logic [7:0] data1;
        mem_addr_t  addr_first;
        mem_addr_t  addr_second;
        int         writes_before;
        random_byte(row_byte);
        random_byte(col_byte);
        random_byte(data0);
        random_byte(data1);
        // byte select lands inverted in the address
        addr_first  = {row_addr_t'(row_byte), col_addr_t'(col_byte), 1'b1};
        addr_second = {row_addr_t'(row_byte), col_addr_t'(col_byte), 1'b0};
        writes_before = write_count;
        send_byte(CMD_READ_PIXEL);
        send_byte(row_byte);
        send_byte(col_byte);
        send_byte(data0);
        send_byte(data1);
        check_flag(test, "busy", 1'b1, busy);
        wait_until_idle(test, 1);
        idle_cycles(1);
        check_count(test, 2, write_count - writes_before);
        check_mem(test, addr_first, data0);
        check_mem(test, addr_second, data1);
    endtask

    task automatic test_blank_panel();
        int writes_before;
        int a;
        repeat (3) write_random_pixel("pixels before blank");
        writes_before = write_count;
        send_byte(CMD_BLANK_PANEL);
        @(negedge clk_in);
        check_flag("blank panel", "busy", 1'b1, busy);
        while (busy) begin
            check_flag("blank panel", "ready_for_data", 1'b0, ready_for_data);
            @(negedge clk_in);
        end
        check_flag("blank panel", "ready_for_data", 1'b1, ready_for_data);
        check_count("blank panel", MEM_BYTES, write_count - writes_before);
        for (a = 0; a < MEM_BYTES; a++) begin
            check_mem("blank panel", mem_addr_t'(a), 8'h00);
        end

        send_byte(CMD_GREEN_DISABLE);
        rgb_model[1] = 1'b0;
        idle_cycles(4);
        check_rgb("opcode after blank", rgb_model, rgb_enable);
    endtask

    initial begin
        int a;
        data_rx      = '0;
        data_ready_n = 1'b1;
        write_count  = 0;
        lfsr_state   = 16'd51203;
        rgb_model    = '1;
        // nonzero start so the blank test sees real clearing
        for (a = 0; a < MEM_BYTES; a++) begin
            shadow[a] = 8'ha5 ^ a[7:0] ^ {a[11:8], a[11:8]};
        end

        @(negedge clk_in);
        while (reset) @(negedge clk_in);
        @(negedge clk_in);

        test_reset_state();
        test_channel_opcodes();
        test_brightness_opcodes();
        test_read_brightness();
        write_random_pixel("read pixel");
        test_blank_panel();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
hdl/panel_pkg.sv
hdl/cmd_dispatch.sv
hdl/cmd_read_brightness.sv
hdl/cmd_read_pixel.sv
hdl/cmd_blank_panel.sv
hdl/panel_control.sv
tb/tb_clock_gen.sv
tb/panel_control_tb.sv

/* Bender.yml */
package:
  name: panel_control

export_include_dirs:
  - include

sources:
  - hdl/panel_pkg.sv
  - hdl/cmd_dispatch.sv
  - hdl/cmd_read_brightness.sv
  - hdl/cmd_read_pixel.sv
  - hdl/cmd_blank_panel.sv
  - hdl/panel_control.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/panel_control_tb.sv
